//--- video_pkg.sv
package video_pkg;

	// horizontal raster in pixels, sync is active low
	localparam int h_active     = 640;
	localparam int h_total      = 800;
	localparam int h_sync_start = 656;
	localparam int h_sync_end   = 752;

	// vertical raster in lines
	localparam int v_active     = 480;
	localparam int v_total      = 525;
	localparam int v_sync_start = 490;
	localparam int v_sync_end   = 492;

	// frame request, six clocks ahead of the first pixel
	localparam int req_x = 794;
	localparam int req_y = 524;

	localparam int cnt_w = 10;

	// DVI control tokens, indexed by {c1, c0}
	localparam logic [9:0] tok_ctrl0 = 10'b1101010100;
	localparam logic [9:0] tok_ctrl1 = 10'b0010101011;
	localparam logic [9:0] tok_ctrl2 = 10'b0101010100;
	localparam logic [9:0] tok_ctrl3 = 10'b1010101011;

	// pixel FIFO word
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb444_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888_t;

	typedef struct packed {
		logic             hsync;
		logic             vsync;
		logic             active;
		logic [cnt_w-1:0] x;
		logic [cnt_w-1:0] y;
	} timing_t;

	typedef struct packed {
		logic [9:0] ch2;
		logic [9:0] ch1;
		logic [9:0] ch0;
	} tmds_sym_t;

	typedef enum logic [1:0] {
		st_wait_first,
		st_wait_second,
		st_active
	} reader_state_e;

endpackage

//--- apb_pkg.sv
package apb_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// enable sits in bit 0 of the control register, gray in bit 1
	typedef struct packed {
		logic gray;
		logic enable;
	} ctrl_t;

	localparam logic [3:0] reg_ctrl   = 4'h0;
	localparam logic [3:0] reg_status = 4'h4;

endpackage

//--- video_timing.sv
module video_timing
	import video_pkg::*;
(
	input  logic    i_p_clk,
	input  logic    i_rstn,
	output timing_t o_timing
);

	logic [cnt_w-1:0] x;
	logic [cnt_w-1:0] y;
	logic             x_last;
	logic             y_last;

	assign x_last = (x == cnt_w'(h_total - 1));
	assign y_last = (y == cnt_w'(v_total - 1));

	// free running raster counters
	always_ff @(posedge i_p_clk) begin
		if (!i_rstn) begin
			x <= '0;
			y <= '0;
		end else if (x_last) begin
			x <= '0;
			if (y_last) begin
				y <= '0;
			end else begin
				y <= y + 1'b1;
			end
		end else begin
			x <= x + 1'b1;
		end
	end

	always_comb begin
		o_timing.x      = x;
		o_timing.y      = y;
		o_timing.active = (x < cnt_w'(h_active)) && (y < cnt_w'(v_active));
		// both syncs are low inside their pulse
		o_timing.hsync  = !((x >= cnt_w'(h_sync_start)) && (x < cnt_w'(h_sync_end)));
		o_timing.vsync  = !((y >= cnt_w'(v_sync_start)) && (y < cnt_w'(v_sync_end)));
	end

	a_x_range: assert property (@(posedge i_p_clk) disable iff (!i_rstn)
		(x < cnt_w'(h_total)) && (y < cnt_w'(v_total)));

endmodule

//--- tmds_encoder.sv
module tmds_encoder
	import video_pkg::*;
(
	input  logic       i_p_clk,
	input  logic       i_rstn,
	input  logic       i_de,
	input  logic       i_c0,
	input  logic       i_c1,
	input  logic [7:0] i_data,
	output logic [9:0] o_sym
);

	logic [3:0]        n1_data;
	logic [3:0]        n1_qm;
	logic              use_xnor;
	logic [8:0]        q_m;
	logic signed [5:0] diff;
	logic signed [5:0] disp;
	logic signed [5:0] disp_nxt;
	logic [9:0]        sym_nxt;
	logic [9:0]        ctrl_sym;

	// ones in the input byte
	always_comb begin
		n1_data = '0;
		for (int i = 0; i < 8; i++) begin
			n1_data = n1_data + {3'b000, i_data[i]};
		end
	end

	assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !i_data[0]);

	// transition minimized word
	always_comb begin
		q_m[0] = i_data[0];
		for (int i = 1; i < 8; i++) begin
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
		end
		q_m[8] = !use_xnor;
	end

	always_comb begin
		n1_qm = '0;
		for (int i = 0; i < 8; i++) begin
			n1_qm = n1_qm + {3'b000, q_m[i]};
		end
	end

	// ones minus zeros of q_m[7:0]
	assign diff = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8;

	// DC balance against the running disparity
	always_comb begin
		if ((disp == 6'sd0) || (diff == 6'sd0)) begin
			sym_nxt  = {!q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
			disp_nxt = q_m[8] ? (disp + diff) : (disp - diff);
		end else if (((disp > 6'sd0) && (diff > 6'sd0)) ||
		             ((disp < 6'sd0) && (diff < 6'sd0))) begin
			sym_nxt  = {1'b1, q_m[8], ~q_m[7:0]};
			disp_nxt = disp + (q_m[8] ? 6'sd2 : 6'sd0) - diff;
		end else begin
			sym_nxt  = {1'b0, q_m[8], q_m[7:0]};
			disp_nxt = disp - (q_m[8] ? 6'sd0 : 6'sd2) + diff;
		end
	end

	always_comb begin
		case ({i_c1, i_c0})
			2'b00:   ctrl_sym = tok_ctrl0;
			2'b01:   ctrl_sym = tok_ctrl1;
			2'b10:   ctrl_sym = tok_ctrl2;
			default: ctrl_sym = tok_ctrl3;
		endcase
	end

	always_ff @(posedge i_p_clk) begin
		if (!i_rstn) begin
			disp  <= '0;
			o_sym <= ctrl_sym;
		end else if (i_de) begin
			disp  <= disp_nxt;
			o_sym <= sym_nxt;
		end else begin
			// blanking restarts the balance from zero
			disp  <= '0;
			o_sym <= ctrl_sym;
		end
	end

	a_disp_bound: assert property (@(posedge i_p_clk) disable iff (!i_rstn)
		(disp >= -6'sd10) && (disp <= 6'sd10));

endmodule

//--- display_interface.sv
module display_interface
	import video_pkg::*, apb_pkg::*;
(
	input  logic          i_p_clk,
	input  logic          i_rstn,
	input  ctrl_t         i_ctrl,
	input  rgb444_t       i_rgb,
	input  logic          i_empty,
	output logic          o_rd,
	output logic          o_req,
	output logic          o_frame_start,
	output reader_state_e o_state,
	output tmds_sym_t     o_tmds
);

	timing_t       timing;
	timing_t       timing_q;
	reader_state_e state;
	reader_state_e state_nxt;
	logic          rd_q;
	logic          rd_nxt;
	logic          frame_pt;
	logic          x_last;
	logic          y_last;
	rgb888_t       pix;

	video_timing u_timing (
		.i_p_clk  (i_p_clk),
		.i_rstn   (i_rstn),
		.o_timing (timing)
	);

	// first blanking pixel after the last active line
	assign frame_pt = (timing.x == cnt_w'(h_active)) && (timing.y == cnt_w'(v_active));
	assign x_last   = (timing.x == cnt_w'(h_total - 1));
	assign y_last   = (timing.y == cnt_w'(v_total - 1));

	always_comb begin
		state_nxt = state;
		rd_nxt    = 1'b0;
		case (state)
			// camera gets two whole frames for configuration
			st_wait_first: begin
				if (frame_pt) begin
					state_nxt = st_wait_second;
				end
			end
			st_wait_second: begin
				if (frame_pt && i_ctrl.enable) begin
					state_nxt = st_active;
				end
			end
			st_active: begin
				if (!i_ctrl.enable) begin
					state_nxt = st_wait_second;
				end else if (timing.y < cnt_w'(v_active)) begin
					// reads run one pixel ahead and stop at x = 638
					rd_nxt = !i_empty && (x_last || (timing.x < cnt_w'(h_active - 1)));
				end else if (y_last) begin
					// start of frame read
					rd_nxt = !i_empty && x_last;
				end else begin
					// vertical blanking drains leftovers
					rd_nxt = !i_empty;
				end
			end
			default: begin
				state_nxt = st_wait_first;
			end
		endcase
	end

	always_ff @(posedge i_p_clk) begin
		if (!i_rstn) begin
			state         <= st_wait_first;
			rd_q          <= 1'b0;
			o_frame_start <= 1'b0;
		end else begin
			state         <= state_nxt;
			rd_q          <= rd_nxt;
			o_frame_start <= (state == st_active) && x_last && y_last;
		end
	end

	// the FIFO may have run dry since the read was scheduled
	assign o_rd    = rd_q && !i_empty;
	assign o_req   = (state == st_active) && (timing.x == cnt_w'(req_x)) &&
	                 (timing.y == cnt_w'(req_y));
	assign o_state = state;

	// pixel formatter holds the last pixel when no word arrives
	always_ff @(posedge i_p_clk) begin
		if (!i_rstn) begin
			timing_q <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0, x: '0, y: '0};
			pix      <= '0;
		end else begin
			timing_q <= timing;
			if (timing.active && o_rd) begin
				if (i_ctrl.gray) begin
					pix.red   <= {i_rgb.red, i_rgb.green};
					pix.green <= {i_rgb.red, i_rgb.green};
					pix.blue  <= {i_rgb.red, i_rgb.green};
				end else begin
					pix.red   <= {i_rgb.red, 4'h0};
					pix.green <= {i_rgb.green, 4'h0};
					pix.blue  <= {i_rgb.blue, 4'h0};
				end
			end
		end
	end

	// blue carries the syncs
	tmds_encoder u_enc_blue (
		.i_p_clk (i_p_clk),
		.i_rstn  (i_rstn),
		.i_de    (timing_q.active),
		.i_c0    (timing_q.hsync),
		.i_c1    (timing_q.vsync),
		.i_data  (pix.blue),
		.o_sym   (o_tmds.ch0)
	);

	tmds_encoder u_enc_green (
		.i_p_clk (i_p_clk),
		.i_rstn  (i_rstn),
		.i_de    (timing_q.active),
		.i_c0    (1'b0),
		.i_c1    (1'b0),
		.i_data  (pix.green),
		.o_sym   (o_tmds.ch1)
	);

	tmds_encoder u_enc_red (
		.i_p_clk (i_p_clk),
		.i_rstn  (i_rstn),
		.i_de    (timing_q.active),
		.i_c0    (1'b0),
		.i_c1    (1'b0),
		.i_data  (pix.red),
		.o_sym   (o_tmds.ch2)
	);

	// no read strobe while the FIFO is empty
	a_rd_safe: assert property (@(posedge i_p_clk) disable iff (!i_rstn)
		o_rd |-> !i_empty);

endmodule

//--- display_regs.sv
module display_regs
	import video_pkg::*, apb_pkg::*;
(
	input  logic          i_p_clk,
	input  logic          i_rstn,
	input  apb_req_t      i_apb,
	output apb_rsp_t      o_apb,
	input  reader_state_e i_state,
	input  logic          i_frame_start,
	output ctrl_t         o_ctrl
);

	ctrl_t       ctrl;
	logic [15:0] frame_cnt;
	logic        access;
	logic        hit_ctrl;
	logic        hit_status;

	assign access     = i_apb.psel && i_apb.penable;
	assign hit_ctrl   = (i_apb.paddr == reg_ctrl);
	assign hit_status = (i_apb.paddr == reg_status);

	always_ff @(posedge i_p_clk) begin
		if (!i_rstn) begin
			ctrl      <= '0;
			frame_cnt <= '0;
		end else begin
			if (access && i_apb.pwrite && hit_ctrl) begin
				ctrl <= ctrl_t'(i_apb.pwdata[1:0]);
			end
			if (i_frame_start) begin
				frame_cnt <= frame_cnt + 16'd1;
			end
		end
	end

	// no wait states, ready in every access phase
	always_comb begin
		o_apb.pready  = access;
		o_apb.prdata  = '0;
		o_apb.pslverr = 1'b0;
		if (access && !i_apb.pwrite) begin
			if (hit_ctrl) begin
				o_apb.prdata = {30'd0, ctrl};
			end else if (hit_status) begin
				o_apb.prdata = {frame_cnt, 14'd0, i_state};
			end
		end
		// status is read only
		if (access && (!(hit_ctrl || hit_status) || (i_apb.pwrite && hit_status))) begin
			o_apb.pslverr = 1'b1;
		end
	end

	assign o_ctrl = ctrl;

	// every access phase follows its setup phase
	a_apb_setup: assert property (@(posedge i_p_clk) disable iff (!i_rstn)
		access |-> $past(i_apb.psel && !i_apb.penable));

endmodule

//--- display_top.sv
module display_top
	import video_pkg::*, apb_pkg::*;
(
	input  logic      i_p_clk,
	input  logic      i_rstn,

	// register bus
	input  apb_req_t  i_apb,
	output apb_rsp_t  o_apb,

	// pixel FIFO, show-ahead
	input  rgb444_t   i_rgb,
	input  logic      i_empty,
	output logic      o_rd,

	// frame request to the memory reader
	output logic      o_req,

	// parallel TMDS symbols
	output tmds_sym_t o_tmds
);

	ctrl_t         ctrl;
	reader_state_e state;
	logic          frame_start;

	display_regs u_regs (
		.i_p_clk       (i_p_clk),
		.i_rstn        (i_rstn),
		.i_apb         (i_apb),
		.o_apb         (o_apb),
		.i_state       (state),
		.i_frame_start (frame_start),
		.o_ctrl        (ctrl)
	);

	display_interface u_disp (
		.i_p_clk       (i_p_clk),
		.i_rstn        (i_rstn),
		.i_ctrl        (ctrl),
		.i_rgb         (i_rgb),
		.i_empty       (i_empty),
		.o_rd          (o_rd),
		.o_req         (o_req),
		.o_frame_start (frame_start),
		.o_state       (state),
		.o_tmds        (o_tmds)
	);

endmodule

//--- tb_display.sv
module tb_display
	import video_pkg::*, apb_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [1:0] {op_none, op_read, op_write} op_e;

	// table row holds a bus access, the empty pattern and the frames to run afterwards
	typedef struct packed {
		op_e         op;
		logic [3:0]  addr;
		logic [31:0] data;
		logic        err;
		logic        mode;
		logic [3:0]  frames;
	} step_t;

	typedef struct packed {
		logic    active;
		logic    hsync;
		logic    vsync;
		rgb888_t pix;
	} disp_t;

	localparam int mark_y = 500;

	logic             i_p_clk = 1'b0;
	logic             i_rstn;
	apb_req_t         i_apb;
	apb_rsp_t         o_apb;
	rgb444_t          i_rgb;
	logic             i_empty;
	logic             o_rd;
	logic             o_req;
	tmds_sym_t        o_tmds;

	logic [cnt_w-1:0] tx;
	logic [cnt_w-1:0] ty;
	logic             frame_pt;
	reader_state_e    exp_state;
	ctrl_t            exp_ctrl;
	logic             empty_mode;
	logic [15:0]      lfsr;
	rgb444_t          served [$];
	disp_t            dly [2];
	rgb888_t          exp_pix;
	logic             sched_q;
	logic             take = 1'b0;
	int               cycles = 0;
	int               cycle_limit;
	int               err_rgb = 0;
	int               err_state = 0;
	int               err_word = 0;
	int               err_bit = 0;
	int               err_other = 0;
	step_t            steps [15];

	always #2 i_p_clk = ~i_p_clk;

	display_top u_dut (.i_p_clk, .i_rstn, .i_apb, .o_apb, .i_rgb, .i_empty, .o_rd, .o_req,
		.o_tmds);

	// 16 bit Galois LFSR with taps 0xB400
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	task automatic draw_bits(input int n, output logic [11:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[10:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// DVI data symbol back to its byte
	function automatic logic [7:0] tmds_decode(input logic [9:0] s);
		logic [7:0] q;
		logic [7:0] d;
		q = s[9] ? ~s[7:0] : s[7:0];
		d[0] = q[0];
		for (int i = 1; i < 8; i++) begin
			d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
		end
		return d;
	endfunction

	// returns {valid, c1, c0}
	function automatic logic [2:0] token_decode(input logic [9:0] s);
		case (s)
			10'b1101010100: return 3'b100;
			10'b0010101011: return 3'b101;
			10'b0101010100: return 3'b110;
			10'b1010101011: return 3'b111;
			default:        return 3'b000;
		endcase
	endfunction

	function automatic rgb888_t expand(input rgb444_t w, input logic gray);
		if (gray) begin
			return '{red: {w.red, w.green}, green: {w.red, w.green}, blue: {w.red, w.green}};
		end
		return '{red: {w.red, 4'h0}, green: {w.green, 4'h0}, blue: {w.blue, 4'h0}};
	endfunction

	function automatic logic [31:0] status_word(input logic [15:0] count, input reader_state_e st);
		return {count, 14'd0, st};
	endfunction

	task automatic check_rgb(input string name, input rgb888_t exp, input rgb888_t got);
		if (got !== exp) begin
			err_rgb++;
			$display("[ERROR] %0d ns %s: expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_state(input string name, input reader_state_e exp,
		input reader_state_e got);
		if (got !== exp) begin
			err_state++;
			$display("[ERROR] %0d ns %s: expected %s got %s", $time, name, exp.name(), got.name());
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			err_word++;
			$display("[ERROR] %0d ns %s: expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			err_bit++;
			$display("[ERROR] %0d ns %s: expected %b got %b", $time, name, exp, got);
		end
	endtask

	// two cycle APB transfer that also updates the ctrl model
	task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge i_p_clk);
		i_apb <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge i_p_clk);
		i_apb.penable <= 1'b1;
		@(negedge i_p_clk);
		check_bit("pready", 1'b1, o_apb.pready);
		rdata = o_apb.prdata;
		err = o_apb.pslverr;
		@(posedge i_p_clk);
		i_apb <= '0;
		if (write && (addr == reg_ctrl)) begin
			exp_ctrl <= ctrl_t'(wdata[1:0]);
		end
	endtask

	task automatic run_frames(input int n);
		for (int i = 0; i < n; i++) begin
			do @(negedge i_p_clk);
			while (!((tx == '0) && (ty == cnt_w'(mark_y))));
		end
	endtask

	assign frame_pt = (tx == cnt_w'(h_active)) && (ty == cnt_w'(v_active));

	// raster and reader state as the DUT should see them
	always @(posedge i_p_clk) begin
		if (!i_rstn) begin
			tx        <= '0;
			ty        <= '0;
			exp_state <= st_wait_first;
		end else begin
			tx <= (tx == cnt_w'(h_total - 1)) ? '0 : tx + 1'b1;
			if (tx == cnt_w'(h_total - 1)) begin
				ty <= (ty == cnt_w'(v_total - 1)) ? '0 : ty + 1'b1;
			end
			if ((exp_state == st_wait_first) && frame_pt) begin
				exp_state <= st_wait_second;
			end else if ((exp_state == st_wait_second) && frame_pt && exp_ctrl.enable) begin
				exp_state <= st_active;
			end else if ((exp_state == st_active) && !exp_ctrl.enable) begin
				exp_state <= st_wait_second;
			end
		end
	end

	// show-ahead FIFO presents a new word after each read
	always @(posedge i_p_clk) begin : fifo_model
		logic [11:0] bits;
		if (take) begin
			draw_bits(12, bits);
			served.push_back(rgb444_t'(bits));
			i_rgb <= rgb444_t'(bits);
		end
		if (empty_mode) begin
			draw_bits(1, bits);
			i_empty <= bits[0];
		end else begin
			i_empty <= 1'b0;
		end
	end

	always @(negedge i_p_clk) begin : check_outputs
		disp_t       cur;
		logic        exp_rd;
		logic        rule;
		logic [2:0]  tok;
		rgb888_t     got;
		rgb444_t     w;
		take = i_rstn && o_rd;
		if (!i_rstn) begin
			dly[0]  = '{active: 1'b0, hsync: 1'b1, vsync: 1'b1, pix: '0};
			dly[1]  = dly[0];
			exp_pix = '0;
			sched_q = 1'b0;
		end else begin
			exp_rd = sched_q && !i_empty;
			check_bit("o_rd", exp_rd, o_rd);
			check_bit("o_req", (exp_state == st_active) && (tx == cnt_w'(req_x)) &&
				(ty == cnt_w'(req_y)), o_req);
			cur.active = (tx < cnt_w'(h_active)) && (ty < cnt_w'(v_active));
			cur.hsync  = !((tx >= cnt_w'(h_sync_start)) && (tx < cnt_w'(h_sync_end)));
			cur.vsync  = !((ty >= cnt_w'(v_sync_start)) && (ty < cnt_w'(v_sync_end)));
			if (exp_rd && (served.size() == 0)) begin
				err_other++;
				$display("a read at %0d ns found no word in the FIFO model", $time);
			end else if (exp_rd) begin
				w = served.pop_front();
				if (cur.active) begin
					exp_pix = expand(w, exp_ctrl.gray);
				end
			end
			cur.pix = exp_pix;
			// symbols lag the raster by two cycles
			if (dly[1].active) begin
				got = {tmds_decode(o_tmds.ch2), tmds_decode(o_tmds.ch1), tmds_decode(o_tmds.ch0)};
				check_rgb("o_tmds", dly[1].pix, got);
			end else begin
				tok = token_decode(o_tmds.ch0);
				if (!tok[2]) begin
					err_other++;
					$display("blue channel sent no control token in blanking at %0d ns", $time);
				end
				check_bit("hsync", dly[1].hsync, tok[0]);
				check_bit("vsync", dly[1].vsync, tok[1]);
				check_bit("ch1 token", 1'b1, o_tmds.ch1 == 10'b1101010100);
				check_bit("ch2 token", 1'b1, o_tmds.ch2 == 10'b1101010100);
			end
			dly[1] = dly[0];
			dly[0] = cur;
			if (ty < cnt_w'(v_active)) begin
				rule = (tx == cnt_w'(h_total - 1)) || (tx < cnt_w'(h_active - 1));
			end else if (ty == cnt_w'(v_total - 1)) begin
				rule = (tx == cnt_w'(h_total - 1));
			end else begin
				rule = 1'b1;
			end
			sched_q = (exp_state == st_active) && exp_ctrl.enable && !i_empty && rule;
		end
	end

	always @(posedge i_p_clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles before the table was done", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		step_t       s;
		logic [11:0] bits;
		logic [31:0] rdata;
		logic        err;
		int          frames;
		int          total;
		i_rstn     = 1'b0;
		i_apb      = '0;
		i_empty    = 1'b0;
		empty_mode = 1'b0;
		exp_ctrl   = '0;
		lfsr       = 16'd96;
		draw_bits(12, bits);
		served.push_back(rgb444_t'(bits));
		i_rgb = rgb444_t'(bits);
		steps = '{
			'{op_read,  reg_status, status_word(16'd0, st_wait_first),  1'b0, 1'b0, 4'd1},
			'{op_read,  reg_status, status_word(16'd0, st_wait_second), 1'b0, 1'b0, 4'd1},
			'{op_read,  reg_status, status_word(16'd0, st_wait_second), 1'b0, 1'b0, 4'd0},
			'{op_write, reg_ctrl,   32'h1,                              1'b0, 1'b0, 4'd0},
			'{op_read,  reg_ctrl,   32'h1,                              1'b0, 1'b0, 4'd1},
			'{op_read,  reg_status, status_word(16'd0, st_active),      1'b0, 1'b0, 4'd1},
			'{op_read,  reg_status, status_word(16'd1, st_active),      1'b0, 1'b0, 4'd0},
			'{op_write, reg_ctrl,   32'h3,                              1'b0, 1'b0, 4'd1},
			'{op_read,  reg_status, status_word(16'd2, st_active),      1'b0, 1'b1, 4'd1},
			'{op_write, reg_ctrl,   32'h1,                              1'b0, 1'b1, 4'd1},
			'{op_read,  4'h8,       32'h0,                              1'b1, 1'b0, 4'd0},
			'{op_write, reg_status, 32'h0,                              1'b1, 1'b0, 4'd0},
			'{op_read,  reg_status, status_word(16'd4, st_active),      1'b0, 1'b0, 4'd0},
			'{op_write, reg_ctrl,   32'h0,                              1'b0, 1'b0, 4'd1},
			'{op_read,  reg_status, status_word(16'd4, st_wait_second), 1'b0, 1'b0, 4'd0}
		};
		frames = 0;
		foreach (steps[i]) begin
			frames += int'(steps[i].frames);
		end
		cycle_limit = frames * 420000 + 1000;
		repeat (3) @(posedge i_p_clk);
		i_rstn <= 1'b1;
		foreach (steps[i]) begin
			s = steps[i];
			if (s.op != op_none) begin
				apb_xfer(s.op == op_write, s.addr, s.data, rdata, err);
				check_bit("pslverr", s.err, err);
				if ((s.op == op_read) && !s.err) begin
					check_word("prdata", s.data, rdata);
					if (s.addr == reg_status) begin
						check_state("status state", reader_state_e'(s.data[1:0]),
							reader_state_e'(rdata[1:0]));
					end
				end
			end
			empty_mode <= s.mode;
			run_frames(int'(s.frames));
		end
		total = err_rgb + err_state + err_word + err_bit + err_other;
		$display("errors: rgb %0d, state %0d, word %0d, bit %0d, other %0d",
			err_rgb, err_state, err_word, err_bit, err_other);
		if (total == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- sim.f
video_pkg.sv
apb_pkg.sv
video_timing.sv
tmds_encoder.sv
display_interface.sv
display_regs.sv
display_top.sv
tb_display.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_display
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
